// File: verilog/dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// ----------------------------------------
// Bus word address map
// ----------------------------------------
`define DMA_FROM_ACM_A         16'd0
`define DMA_FROM_LC_A          16'd40
`define DMA_FROM_DEPTH         128
`define DMA_LC_THRESHS_A       16'd128
`define DMA_ACM_AQUADS_A       16'd384
`define DMA_VS_INDIRECT_A      16'd512
`define DMA_SYSCONFIG_A        16'd576
`define DMA_FLASH_A            16'd1024
`define DMA_FLASH_DEPTH        256
`define DMA_FLASH_SYSCONFIG_A  16'hffff

`define DMA_LC_COUNT           64      // Thresholds copied per boot
`define DMA_ACM_COUNT          40      // Coefficients copied per boot
`define DMA_TRACE_DEPTH        256

`define DMA_WORD_W             16
`define DMA_ADR_W              16
`define DMA_PROGRESS_W         9
`define DMA_FROM_AW            7       // Index width of the FROM array
`define DMA_FLASH_AW           8
`define DMA_TRACE_AW           8
`define DMA_REG_AW             6       // Index width of threshold and coefficient banks

`endif

// File: verilog/dma_pkg.sv
`include "dma_consts.svh"

package dma_pkg;

  typedef logic [`DMA_WORD_W-1:0]     bus_word_t;
  typedef logic [`DMA_ADR_W-1:0]      bus_adr_t;
  typedef logic [`DMA_PROGRESS_W-1:0] progress_t;

  typedef enum logic [2:0] {
    MODE_FLASH,
    MODE_LC,
    MODE_ACM,
    MODE_SYSCONFIG,
    MODE_DONE
  } dma_mode_e;

  typedef enum logic [1:0] {
    STEP_REQ,
    STEP_READ_WAIT,
    STEP_WRITE_WAIT,
    STEP_CLOSE_WAIT         // Single write whose ack only moves the sequence on
  } dma_step_e;

endpackage

// File: verilog/wb_bus_if.sv
`timescale 1ns/10ps

interface wb_bus_if import dma_pkg::*; ();

  logic      cyc;
  logic      stb;           // High for exactly one cycle per transfer
  logic      we;
  bus_adr_t  adr;
  bus_word_t dat_w;
  bus_word_t dat_r;         // Valid only in the ack cycle
  logic      ack;
  logic      err;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

// File: verilog/dma_engine.sv
`timescale 1ns/10ps

`include "dma_consts.svh"

module dma_engine import dma_pkg::*; (
  input  logic     wb_clk_i,
  input  logic     soft_reset,
  input  logic     dma_crash_i,
  wb_bus_if.master bus,
  output logic     dma_done_o
);

  dma_mode_e mode;
  dma_mode_e next_mode;
  dma_step_e step;
  progress_t progress;
  logic      stb_q;
  logic      we_q;
  bus_adr_t  adr_q;
  bus_word_t dat_q;
  bus_adr_t  rd_adr;
  bus_adr_t  wr_adr;
  bus_word_t wr_dat;
  logic      last;
  logic      resp;

  assign bus.cyc    = stb_q;
  assign bus.stb    = stb_q;
  assign bus.we     = we_q;
  assign bus.adr    = adr_q;
  assign bus.dat_w  = dat_q;
  assign resp       = bus.ack | bus.err;          // An err closes a transfer just like an ack
  assign dma_done_o = (mode == MODE_DONE);

  // ----------------------------------------
  // Per-mode source, target and data rule
  // ----------------------------------------
  always_comb begin
    rd_adr    = `DMA_VS_INDIRECT_A;                // Crash backup drains the trace port
    wr_adr    = `DMA_FLASH_A + bus_adr_t'(progress) - 16'd1;
    wr_dat    = bus.dat_r;
    last      = dat_q[15] || (progress == progress_t'(`DMA_FLASH_DEPTH));
    next_mode = MODE_LC;
    case (mode)
      MODE_LC: begin
        rd_adr    = `DMA_FROM_LC_A + bus_adr_t'(progress);
        wr_adr    = `DMA_LC_THRESHS_A + bus_adr_t'(progress);
        wr_dat    = (bus.dat_r == 16'h00ff) ? 16'h0fff : {bus.dat_r[11:0], 4'h0};
        last      = (progress == progress_t'(`DMA_LC_COUNT - 1));
        next_mode = MODE_ACM;
      end
      MODE_ACM: begin
        rd_adr    = `DMA_FROM_ACM_A + bus_adr_t'(progress);
        wr_adr    = `DMA_ACM_AQUADS_A + bus_adr_t'(progress);
        last      = (progress == progress_t'(`DMA_ACM_COUNT - 1));
        next_mode = MODE_SYSCONFIG;
      end
      MODE_SYSCONFIG: begin
        rd_adr    = `DMA_FLASH_SYSCONFIG_A;
        wr_adr    = `DMA_SYSCONFIG_A;
        wr_dat    = (bus.dat_r > 16'h00ff) ? 16'h0000 : bus.dat_r;  // Unprogrammed flash
        last      = 1'b1;
        next_mode = MODE_DONE;
      end
      default: begin
      end
    endcase
  end

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge wb_clk_i) begin
    stb_q <= 1'b0;
    if (soft_reset) begin
      mode     <= dma_crash_i ? MODE_FLASH : MODE_LC;
      step     <= STEP_REQ;
      progress <= '0;
    end else begin
      case (step)
        STEP_REQ: begin
          if (mode == MODE_FLASH && progress == '0) begin
            stb_q <= 1'b1;                        // Rewind the trace read pointer
            we_q  <= 1'b1;
            adr_q <= `DMA_VS_INDIRECT_A;
            dat_q <= 16'h0000;
            step  <= STEP_CLOSE_WAIT;
          end else if (mode != MODE_DONE) begin
            stb_q <= 1'b1;
            we_q  <= 1'b0;
            adr_q <= rd_adr;
            step  <= STEP_READ_WAIT;
          end
        end
        STEP_READ_WAIT: begin
          if (resp) begin
            stb_q <= 1'b1;                        // Write chained right after the read
            we_q  <= 1'b1;
            adr_q <= wr_adr;
            dat_q <= wr_dat;
            step  <= STEP_WRITE_WAIT;
          end
        end
        STEP_WRITE_WAIT: begin
          if (resp) begin
            if (!last) begin
              progress <= progress + 1'b1;
              step     <= STEP_REQ;
            end else if (mode == MODE_FLASH) begin
              stb_q <= 1'b1;                      // Empty the trace buffer
              we_q  <= 1'b1;
              adr_q <= `DMA_VS_INDIRECT_A;
              dat_q <= 16'hffff;
              step  <= STEP_CLOSE_WAIT;
            end else begin
              mode     <= next_mode;
              progress <= '0;
              step     <= STEP_REQ;
            end
          end
        end
        STEP_CLOSE_WAIT: begin
          if (resp) begin
            if (progress == '0) begin
              progress <= progress_t'(1);         // Rewind done, start the drain
            end else begin
              mode     <= MODE_LC;
              progress <= '0;
            end
            step <= STEP_REQ;
          end
        end
        default: begin
          step <= STEP_REQ;
        end
      endcase
    end
  end

endmodule

// File: verilog/boot_bus_decoder.sv
`timescale 1ns/10ps

`include "dma_consts.svh"

module boot_bus_decoder (
  input  logic     wb_clk_i,
  input  logic     soft_reset,
  wb_bus_if.slave  cpu_bus,
  wb_bus_if.master store_bus,
  wb_bus_if.master regs_bus
);

  logic sel_store;
  logic sel_regs;
  logic unmapped_q;                               // Strobe to a hole seen last cycle

  always_comb begin
    sel_store = (cpu_bus.adr < `DMA_FROM_DEPTH) ||
                (cpu_bus.adr >= `DMA_FLASH_A &&
                 cpu_bus.adr < `DMA_FLASH_A + `DMA_FLASH_DEPTH) ||
                (cpu_bus.adr == `DMA_FLASH_SYSCONFIG_A);
    sel_regs  = (cpu_bus.adr >= `DMA_LC_THRESHS_A) && (cpu_bus.adr < `DMA_FLASH_A);
  end

  assign store_bus.cyc   = cpu_bus.cyc & sel_store;
  assign store_bus.stb   = cpu_bus.stb & sel_store;
  assign store_bus.we    = cpu_bus.we;
  assign store_bus.adr   = cpu_bus.adr;
  assign store_bus.dat_w = cpu_bus.dat_w;

  assign regs_bus.cyc    = cpu_bus.cyc & sel_regs;
  assign regs_bus.stb    = cpu_bus.stb & sel_regs;
  assign regs_bus.we     = cpu_bus.we;
  assign regs_bus.adr    = cpu_bus.adr;
  assign regs_bus.dat_w  = cpu_bus.dat_w;

  assign cpu_bus.ack   = store_bus.ack | regs_bus.ack;
  assign cpu_bus.err   = store_bus.err | regs_bus.err | unmapped_q;
  assign cpu_bus.dat_r = store_bus.ack ? store_bus.dat_r : regs_bus.dat_r;

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= cpu_bus.cyc & cpu_bus.stb & ~sel_store & ~sel_regs;
    end
  end

endmodule

// File: verilog/cfg_store.sv
`timescale 1ns/10ps

`include "dma_consts.svh"

module cfg_store import dma_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      soft_reset,
  input  logic      load_we_i,
  input  bus_adr_t  load_adr_i,
  input  bus_word_t load_dat_i,
  wb_bus_if.slave   bus,
  input  bus_adr_t  peek_adr_i,
  output bus_word_t peek_dat_o
);

  bus_word_t  from_mem  [`DMA_FROM_DEPTH];
  bus_word_t  flash_mem [`DMA_FLASH_DEPTH];
  bus_word_t  flash_sysconfig;
  logic [1:0] wait_cnt;                           // Zero when idle
  logic       we_q;
  bus_adr_t   adr_q;
  bus_word_t  dat_w_q;
  bus_word_t  dat_r_q;
  logic       ack_q;
  logic       err_q;
  logic       from_wr;
  logic       mem_we;
  bus_adr_t   mem_adr;
  bus_adr_t   mem_off;
  bus_word_t  mem_dat;

  function automatic logic in_flash(bus_adr_t a);
    return (a >= `DMA_FLASH_A) && (a < `DMA_FLASH_A + `DMA_FLASH_DEPTH);
  endfunction

  function automatic bus_word_t read_word(bus_adr_t a);
    bus_adr_t off;
    off = a - `DMA_FLASH_A;
    if (a == `DMA_FLASH_SYSCONFIG_A) return flash_sysconfig;
    else if (a < `DMA_FROM_DEPTH) return from_mem[a[`DMA_FROM_AW-1:0]];
    else if (in_flash(a)) return flash_mem[off[`DMA_FLASH_AW-1:0]];
    else return '0;
  endfunction

  // One write port shared by the preload path and the bus
  always_comb begin
    from_wr = we_q && (adr_q < `DMA_FROM_DEPTH);  // FROM is read-only from the bus
    if (soft_reset) begin
      mem_we  = load_we_i;
      mem_adr = load_adr_i;
      mem_dat = load_dat_i;
    end else begin
      mem_we  = (wait_cnt == 2'd2) && we_q && !from_wr;
      mem_adr = adr_q;
      mem_dat = dat_w_q;
    end
    mem_off = mem_adr - `DMA_FLASH_A;
  end

  always_ff @(posedge wb_clk_i) begin
    if (mem_we) begin
      if (mem_adr == `DMA_FLASH_SYSCONFIG_A) flash_sysconfig <= mem_dat;
      else if (mem_adr < `DMA_FROM_DEPTH) from_mem[mem_adr[`DMA_FROM_AW-1:0]] <= mem_dat;
      else if (in_flash(mem_adr)) flash_mem[mem_off[`DMA_FLASH_AW-1:0]] <= mem_dat;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    ack_q <= 1'b0;
    err_q <= 1'b0;
    if (soft_reset) begin
      wait_cnt <= 2'd0;
    end else if (bus.cyc && bus.stb) begin
      wait_cnt <= 2'd1;
    end else if (wait_cnt == 2'd2) begin
      wait_cnt <= 2'd0;                           // Second wait state over, answer now
      ack_q    <= !from_wr;
      err_q    <= from_wr;
    end else if (wait_cnt != 2'd0) begin
      wait_cnt <= wait_cnt + 2'd1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (bus.cyc && bus.stb) begin
      we_q    <= bus.we;
      adr_q   <= bus.adr;
      dat_w_q <= bus.dat_w;
    end
    if (wait_cnt == 2'd2) dat_r_q <= read_word(adr_q);
  end

  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign bus.dat_r = dat_r_q;

  always_comb peek_dat_o = read_word(peek_adr_i);

endmodule

// File: verilog/cfg_regs.sv
`timescale 1ns/10ps

`include "dma_consts.svh"

module cfg_regs import dma_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      soft_reset,
  input  logic      trace_we_i,
  input  bus_word_t trace_dat_i,
  wb_bus_if.slave   bus,
  input  bus_adr_t  peek_adr_i,
  output bus_word_t peek_dat_o
);

  bus_word_t              lc_thresh [`DMA_LC_COUNT];
  bus_word_t              acm_coef  [`DMA_ACM_COUNT];
  bus_word_t              sysconfig;
  bus_word_t              trace_mem [`DMA_TRACE_DEPTH];
  logic [`DMA_TRACE_AW:0] trace_cnt;              // Words held, one bit wider than the index
  logic [`DMA_TRACE_AW:0] rd_ptr;
  logic                   req;
  logic                   hit;
  logic                   ack_q;
  logic                   err_q;
  bus_word_t              dat_r_q;
  bus_adr_t               lc_off;
  bus_adr_t               acm_off;

  function automatic logic is_lc(bus_adr_t a);
    return (a >= `DMA_LC_THRESHS_A) && (a < `DMA_LC_THRESHS_A + `DMA_LC_COUNT);
  endfunction

  function automatic logic is_acm(bus_adr_t a);
    return (a >= `DMA_ACM_AQUADS_A) && (a < `DMA_ACM_AQUADS_A + `DMA_ACM_COUNT);
  endfunction

  function automatic bus_word_t read_reg(bus_adr_t a);
    bus_adr_t off_lc;
    bus_adr_t off_acm;
    off_lc  = a - `DMA_LC_THRESHS_A;
    off_acm = a - `DMA_ACM_AQUADS_A;
    if (is_lc(a)) return lc_thresh[off_lc[`DMA_REG_AW-1:0]];
    else if (is_acm(a)) return acm_coef[off_acm[`DMA_REG_AW-1:0]];
    else if (a == `DMA_VS_INDIRECT_A) begin
      // Past the last stored word the port reads as an end marker
      return (rd_ptr < trace_cnt) ? trace_mem[rd_ptr[`DMA_TRACE_AW-1:0]] : 16'hffff;
    end
    else if (a == `DMA_SYSCONFIG_A) return sysconfig;
    else return '0;
  endfunction

  assign req     = bus.cyc & bus.stb;
  assign lc_off  = bus.adr - `DMA_LC_THRESHS_A;
  assign acm_off = bus.adr - `DMA_ACM_AQUADS_A;
  assign hit     = is_lc(bus.adr) || is_acm(bus.adr) ||
                   bus.adr == `DMA_VS_INDIRECT_A || bus.adr == `DMA_SYSCONFIG_A;

  // ----------------------------------------
  // Trace pointers and response
  // ----------------------------------------
  always_ff @(posedge wb_clk_i) begin
    ack_q <= 1'b0;
    err_q <= 1'b0;
    if (soft_reset) begin
      rd_ptr <= '0;
      // A fill is one unbroken burst of trace_we_i during reset
      if (!trace_we_i) trace_cnt <= '0;
      else if (trace_cnt != `DMA_TRACE_DEPTH) trace_cnt <= trace_cnt + 1'b1;
    end else if (req) begin
      ack_q <= hit;
      err_q <= !hit;                              // Holes inside the bank
      if (bus.adr == `DMA_VS_INDIRECT_A) begin
        if (!bus.we && rd_ptr < trace_cnt) rd_ptr <= rd_ptr + 1'b1;
        else if (bus.we && bus.dat_w == 16'h0000) rd_ptr <= '0;
        else if (bus.we && bus.dat_w == 16'hffff) begin
          rd_ptr    <= '0;
          trace_cnt <= '0;
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      for (int i = 0; i < `DMA_LC_COUNT; i++) begin
        lc_thresh[i] <= '0;
      end
      sysconfig <= '0;
    end else if (req && bus.we) begin
      if (is_lc(bus.adr)) lc_thresh[lc_off[`DMA_REG_AW-1:0]] <= bus.dat_w;
      else if (bus.adr == `DMA_SYSCONFIG_A) sysconfig <= bus.dat_w;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset && trace_we_i && trace_cnt != `DMA_TRACE_DEPTH) begin
      trace_mem[trace_cnt[`DMA_TRACE_AW-1:0]] <= trace_dat_i;
    end
    if (req && bus.we && is_acm(bus.adr)) acm_coef[acm_off[`DMA_REG_AW-1:0]] <= bus.dat_w;
    if (req) dat_r_q <= read_reg(bus.adr);        // Sampled before the read pointer moves
  end

  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign bus.dat_r = dat_r_q;

  always_comb peek_dat_o = read_reg(peek_adr_i);

endmodule

// File: verilog/dma_boot_top.sv
`timescale 1ns/10ps

module dma_boot_top import dma_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      soft_reset,
  input  logic      dma_crash_i,
  input  logic      load_we_i,
  input  bus_adr_t  load_adr_i,
  input  bus_word_t load_dat_i,
  input  logic      trace_we_i,
  input  bus_word_t trace_dat_i,
  input  bus_adr_t  mem_peek_adr_i,
  output bus_word_t mem_peek_dat_o,
  input  bus_adr_t  reg_peek_adr_i,
  output bus_word_t reg_peek_dat_o,
  output logic      wb_cyc_o,
  output logic      wb_we_o,
  output bus_adr_t  wb_adr_o,
  output logic      wb_ack_o,
  output logic      wb_err_o,
  output logic      dma_done_o
);

  wb_bus_if cpu_bus ();
  wb_bus_if store_bus ();
  wb_bus_if regs_bus ();

  // Engine side of the bus, visible for monitoring
  assign wb_cyc_o = cpu_bus.cyc;
  assign wb_we_o  = cpu_bus.we;
  assign wb_adr_o = cpu_bus.adr;
  assign wb_ack_o = cpu_bus.ack;
  assign wb_err_o = cpu_bus.err;

  dma_engine u_engine (
    .wb_clk_i    (wb_clk_i),
    .soft_reset  (soft_reset),
    .dma_crash_i (dma_crash_i),
    .bus         (cpu_bus.master),
    .dma_done_o  (dma_done_o)
  );

  boot_bus_decoder u_decoder (
    .wb_clk_i   (wb_clk_i),
    .soft_reset (soft_reset),
    .cpu_bus    (cpu_bus.slave),
    .store_bus  (store_bus.master),
    .regs_bus   (regs_bus.master)
  );

  cfg_store u_store (
    .wb_clk_i   (wb_clk_i),
    .soft_reset (soft_reset),
    .load_we_i  (load_we_i),
    .load_adr_i (load_adr_i),
    .load_dat_i (load_dat_i),
    .bus        (store_bus.slave),
    .peek_adr_i (mem_peek_adr_i),
    .peek_dat_o (mem_peek_dat_o)
  );

  cfg_regs u_regs (
    .wb_clk_i    (wb_clk_i),
    .soft_reset  (soft_reset),
    .trace_we_i  (trace_we_i),
    .trace_dat_i (trace_dat_i),
    .bus         (regs_bus.slave),
    .peek_adr_i  (reg_peek_adr_i),
    .peek_dat_o  (reg_peek_dat_o)
  );

endmodule

// File: verif/dma_boot_asserts.sv
`timescale 1ns/10ps

module dma_boot_asserts (
  input logic wb_clk_i,
  input logic soft_reset,
  input logic wb_cyc_o,
  input logic wb_ack_o,
  input logic wb_err_o,
  input logic dma_done_o
);

  logic       open_q;                                // A transfer waits for its answer
  logic [3:0] wait_q;

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset || wb_ack_o || wb_err_o) begin
      open_q <= 1'b0;
      wait_q <= '0;
    end else if (wb_cyc_o || open_q) begin
      open_q <= 1'b1;
      if (wait_q != 4'hf) wait_q <= wait_q + 4'd1;   // Saturates on a hang
    end
  end

  a_stb_pulse: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    wb_cyc_o |=> !wb_cyc_o) else $error("bus strobe longer than one cycle");

  a_no_overlap: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    wb_cyc_o |-> !open_q) else $error("bus strobe while a transfer is open");

  a_resp_time: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    wait_q <= 4'd8) else $error("no ack or err within 8 cycles of a strobe");

  a_done_sticky: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    dma_done_o |=> dma_done_o) else $error("dma_done_o fell without a reset");

endmodule

bind dma_boot_top dma_boot_asserts u_asserts (
  .wb_clk_i   (wb_clk_i),
  .soft_reset (soft_reset),
  .wb_cyc_o   (wb_cyc_o),
  .wb_ack_o   (wb_ack_o),
  .wb_err_o   (wb_err_o),
  .dma_done_o (dma_done_o)
);

// File: verif/dma_boot_tb.sv
`timescale 1ns/10ps

`include "dma_consts.svh"

module dma_boot_tb import dma_pkg::*; ();

  localparam int NUM_TESTS   = 4;
  localparam int WATCHDOG_NS = NUM_TESTS * 1200 * 5 * 40;  // Tests times transfers times cycles

  logic      wb_clk_i = 1'b0;
  logic      soft_reset;
  logic      dma_crash_i;
  logic      load_we_i;
  bus_adr_t  load_adr_i;
  bus_word_t load_dat_i;
  logic      trace_we_i;
  bus_word_t trace_dat_i;
  bus_adr_t  mem_peek_adr_i;
  bus_word_t mem_peek_dat_o;
  bus_adr_t  reg_peek_adr_i;
  bus_word_t reg_peek_dat_o;
  logic      wb_cyc_o;
  logic      wb_we_o;
  bus_adr_t  wb_adr_o;
  logic      wb_ack_o;
  logic      wb_err_o;
  logic      dma_done_o;

  bus_word_t   from_m  [`DMA_FROM_DEPTH];
  bus_word_t   flash_m [`DMA_FLASH_DEPTH];
  bus_word_t   trace_m [`DMA_TRACE_DEPTH];
  bus_word_t   sys_m;
  int          trace_len;
  int          err_count;
  int          check_count;
  int          test_errs;
  string       test_name;
  logic [16:0] xfer_q [$];                              // We and address of each strobe
  int          bus_errs;

  dma_boot_top uut (.*);

  always #20 wb_clk_i = ~wb_clk_i;

  // ----------------------------------------
  // Bus monitor
  // ----------------------------------------
  always @(negedge wb_clk_i) begin
    if (soft_reset) begin
      xfer_q.delete();
      bus_errs = 0;
    end else begin
      if (wb_cyc_o) xfer_q.push_back({wb_we_o, wb_adr_o});
      if (wb_err_o) bus_errs++;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic bus_word_t scale_thresh(bus_word_t src);
    if (src == 16'h00ff) return 16'h0fff;             // Source 0x00ff disables the high limit
    return src << 4;
  endfunction

  function automatic bus_word_t sane_sysconfig(bus_word_t w);
    if (w <= 16'h00ff) return w;
    return 16'h0000;
  endfunction

  function automatic bus_word_t random_source();
    bus_word_t w;
    w = bus_word_t'($urandom);
    if ($urandom_range(7) == 0) w = 16'h00ff;
    return w;
  endfunction

  function automatic bus_word_t random_trace();
    bus_word_t w;
    w = bus_word_t'($urandom) & 16'h7fff;
    if ($urandom_range(31) == 0) w[15] = 1'b1;         // Marks the end of a crash trace
    return w;
  endfunction

  // ----------------------------------------
  // Stimulus and checks
  // ----------------------------------------
  task automatic reset_and_preload(input logic crash, input int sys_kind);
    int n;
    int t0;
    n = `DMA_FROM_DEPTH + `DMA_FLASH_DEPTH + 1;
    for (int i = 0; i < `DMA_FROM_DEPTH; i++) from_m[i] = random_source();
    for (int i = 0; i < `DMA_FLASH_DEPTH; i++) flash_m[i] = bus_word_t'($urandom);
    for (int i = 0; i < `DMA_TRACE_DEPTH; i++) trace_m[i] = random_trace();
    trace_len = $urandom_range(`DMA_TRACE_DEPTH, 1);
    case (sys_kind)
      0: sys_m = 16'h00ff;
      1: sys_m = bus_word_t'($urandom_range(255));
      default: sys_m = bus_word_t'($urandom_range(16'hffff, 16'h0100));
    endcase
    t0 = n - trace_len;                                 // Trace burst ends with the reset
    @(posedge wb_clk_i);
    soft_reset  <= 1'b1;
    dma_crash_i <= crash;
    for (int c = 0; c < n; c++) begin
      load_we_i <= 1'b1;
      if (c < `DMA_FROM_DEPTH) begin
        load_adr_i <= bus_adr_t'(c);
        load_dat_i <= from_m[c];
      end else if (c < `DMA_FROM_DEPTH + `DMA_FLASH_DEPTH) begin
        load_adr_i <= `DMA_FLASH_A + bus_adr_t'(c - `DMA_FROM_DEPTH);
        load_dat_i <= flash_m[c - `DMA_FROM_DEPTH];
      end else begin
        load_adr_i <= `DMA_FLASH_SYSCONFIG_A;
        load_dat_i <= sys_m;
      end
      trace_we_i  <= (c >= t0);
      trace_dat_i <= (c >= t0) ? trace_m[c - t0] : 16'h0000;
      @(posedge wb_clk_i);
    end
    soft_reset <= 1'b0;
    load_we_i  <= 1'b0;
    trace_we_i <= 1'b0;
  endtask

  task automatic wait_for_done();
    @(negedge wb_clk_i);
    if (dma_done_o !== 1'b0) begin
      err_count++;
      test_errs++;
      $display("Test %s: dma_done_o was not low after the soft reset", test_name);
    end
    while (dma_done_o !== 1'b1) @(negedge wb_clk_i);
  endtask

  task automatic check_word(input string what, input int idx, input bus_word_t exp,
                            input bus_word_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      test_errs++;
      $display("** Error %s %s[%0d]: expected 0x%04h, actual 0x%04h",
               test_name, what, idx, exp, act);
    end
  endtask

  task automatic peek_reg(input bus_adr_t a, output bus_word_t d);
    @(posedge wb_clk_i);
    reg_peek_adr_i <= a;
    @(negedge wb_clk_i);
    d = reg_peek_dat_o;
  endtask

  task automatic peek_mem(input bus_adr_t a, output bus_word_t d);
    @(posedge wb_clk_i);
    mem_peek_adr_i <= a;
    @(negedge wb_clk_i);
    d = mem_peek_dat_o;
  endtask

  task automatic check_transfers(input logic crash);
    logic [16:0] exp_q [$];
    bus_word_t   w;
    logic        stop;
    logic        seen_bad;
    if (crash) begin
      exp_q.push_back({1'b1, `DMA_VS_INDIRECT_A});     // Rewind of the trace port
      stop = 1'b0;
      for (int k = 0; k < `DMA_FLASH_DEPTH && !stop; k++) begin
        w = (k < trace_len) ? trace_m[k] : 16'hffff;
        exp_q.push_back({1'b0, `DMA_VS_INDIRECT_A});
        exp_q.push_back({1'b1, `DMA_FLASH_A + bus_adr_t'(k)});
        stop = w[15];
      end
      exp_q.push_back({1'b1, `DMA_VS_INDIRECT_A});
    end
    for (int i = 0; i < `DMA_LC_COUNT; i++) begin
      exp_q.push_back({1'b0, `DMA_FROM_LC_A + bus_adr_t'(i)});
      exp_q.push_back({1'b1, `DMA_LC_THRESHS_A + bus_adr_t'(i)});
    end
    for (int i = 0; i < `DMA_ACM_COUNT; i++) begin
      exp_q.push_back({1'b0, `DMA_FROM_ACM_A + bus_adr_t'(i)});
      exp_q.push_back({1'b1, `DMA_ACM_AQUADS_A + bus_adr_t'(i)});
    end
    exp_q.push_back({1'b0, `DMA_FLASH_SYSCONFIG_A});
    exp_q.push_back({1'b1, `DMA_SYSCONFIG_A});
    check_count++;
    if (xfer_q.size() != exp_q.size()) begin
      err_count++;
      test_errs++;
      $display("** Error %s transfer count: expected %0d, actual %0d",
               test_name, exp_q.size(), xfer_q.size());
    end else begin
      seen_bad = 1'b0;
      for (int i = 0; i < exp_q.size() && !seen_bad; i++) begin
        if (xfer_q[i] !== exp_q[i]) begin
          seen_bad = 1'b1;
          err_count++;
          test_errs++;
          $display("** Error %s transfer[%0d]: expected we=%b adr=0x%04h, actual we=%b adr=0x%04h",
                   test_name, i, exp_q[i][16], exp_q[i][15:0], xfer_q[i][16], xfer_q[i][15:0]);
        end
      end
    end
    check_count++;
    if (bus_errs != 0) begin
      err_count++;
      test_errs++;
      $display("** Error %s bus err responses: expected 0, actual %0d", test_name, bus_errs);
    end
  endtask

  task automatic check_results(input logic crash);
    bus_word_t got;
    bus_word_t w;
    bus_word_t exp_flash [`DMA_FLASH_DEPTH];
    logic      stop;
    for (int i = 0; i < `DMA_LC_COUNT; i++) begin
      peek_reg(`DMA_LC_THRESHS_A + bus_adr_t'(i), got);
      check_word("thresh", i, scale_thresh(from_m[`DMA_FROM_LC_A + i]), got);
    end
    for (int i = 0; i < `DMA_ACM_COUNT; i++) begin
      peek_reg(`DMA_ACM_AQUADS_A + bus_adr_t'(i), got);
      check_word("coef", i, from_m[`DMA_FROM_ACM_A + i], got);
    end
    peek_reg(`DMA_SYSCONFIG_A, got);
    check_word("sysconfig", 0, sane_sysconfig(sys_m), got);
    exp_flash = flash_m;
    stop = !crash;
    for (int k = 0; k < `DMA_FLASH_DEPTH && !stop; k++) begin
      w = (k < trace_len) ? trace_m[k] : 16'hffff;     // An empty trace port reads as 0xffff
      exp_flash[k] = w;
      stop = w[15];
    end
    for (int i = 0; i < `DMA_FLASH_DEPTH; i++) begin
      peek_mem(`DMA_FLASH_A + bus_adr_t'(i), got);
      check_word("flash", i, exp_flash[i], got);
    end
    if (dma_done_o !== 1'b1) begin
      err_count++;
      test_errs++;
      $display("Test %s: dma_done_o fell before the next soft reset", test_name);
    end
  endtask

  task automatic run_boot(input string name, input logic crash, input int sys_kind);
    test_name = name;
    test_errs = 0;
    reset_and_preload(crash, sys_kind);
    wait_for_done();
    check_transfers(crash);
    check_results(crash);
    $display("Test %s finished with %0d mismatch(es)", name, test_errs);
  endtask

  initial begin
    void'($urandom(32'hcc2e_1554));
    soft_reset     = 1'b1;
    dma_crash_i    = 1'b0;
    load_we_i      = 1'b0;
    load_adr_i     = '0;
    load_dat_i     = '0;
    trace_we_i     = 1'b0;
    trace_dat_i    = '0;
    mem_peek_adr_i = '0;
    reg_peek_adr_i = '0;
    err_count      = 0;
    check_count    = 0;
    run_boot("normal_boot", 1'b0, 0);
    run_boot("crash_boot", 1'b1, 1);
    run_boot("reboot", 1'b0, 2);
    run_boot("crash_reboot", 1'b1, 2);
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_count, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the boot sequence never finished", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule

// File: dma_boot_top.f
+incdir+verilog
verilog/dma_pkg.sv
verilog/wb_bus_if.sv
verilog/dma_engine.sv
verilog/boot_bus_decoder.sv
verilog/cfg_store.sv
verilog/cfg_regs.sv
verilog/dma_boot_top.sv
verif/dma_boot_asserts.sv
verif/dma_boot_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the fail message
verilator --binary --timing --assert -Wno-fatal -f dma_boot_top.f --top-module dma_boot_tb \
    -o dma_boot_sim > build.log 2>&1 &&
  ./obj_dir/dma_boot_sim > sim.log 2>&1 &&
  ! grep -q "Errors found" sim.log &&
  grep -q "No errors" sim.log &&
  echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
